//--- dyn_pkg.sv
// shared widths, constants and record types for the dynode readout
// FIFO_DEPTH must stay a power of two since the FIFO pointers wrap freely
// energy shares the corrected sample width
`default_nettype none

package dyn_pkg;

   localparam int SAMPLE_W         = 8;      // raw adc
   localparam int BLCOR_W          = 12;     // baseline corrected, also energy
   localparam int TIME_W           = 24;     // event time
   localparam int TIME_WHOLE_W     = 8;      // time bits 19..12
   localparam int TIME_FRAC_W      = 12;     // time bits 11..0
   localparam int WORD_W           = 16;     // readout fifo word
   localparam int MCU_CODE_W       = 8;
   localparam int NUM_CHANNELS     = 4;      // one-hot mask width
   localparam int NWORDS_W         = 6;      // holds word counts up to 33

   localparam int HIST_BASE_DELAY  = 6;      // fixed part of sample delay
   localparam int HIST_MAX_TAP     = 15;     // pipeline_len range
   localparam int HIST_DEPTH       = HIST_BASE_DELAY + HIST_MAX_TAP - 1;
   localparam int HIST_TAP_W       = $clog2(HIST_DEPTH);

   localparam logic [WORD_W-1:0]     RECORD_PREAMBLE = 16'hA5A5;
   localparam logic [MCU_CODE_W-1:0] MCU_IDLE_CODE   = 8'hFF;  // no event
   localparam logic [MCU_CODE_W-1:0] MCU_SAT_CODE    = 8'hF8;  // fraction saturated

   localparam int FIFO_DEPTH       = 64;
   localparam int FIFO_NEARLY_FULL = 56;
   localparam int FIFO_AW          = $clog2(FIFO_DEPTH);
   localparam int FIFO_CW          = $clog2(FIFO_DEPTH + 1);  // count incl. full

   typedef enum logic [1:0] {
      MODE_ENERGY      = 2'd0,   // energy word only
      MODE_RAW         = 2'd1,   // 32 raw samples
      MODE_BLCOR_LONG  = 2'd2,   // 32 corrected samples
      MODE_BLCOR_SHORT = 2'd3    // 16 corrected samples
   } data_mode_e;

   typedef enum logic [2:0] {
      ST_IDLE,
      ST_PREAMBLE,
      ST_NWORDS,
      ST_MASK,
      ST_DATA
   } framer_state_e;

   typedef struct packed {
      logic [SAMPLE_W-1:0] raw;
      logic [BLCOR_W-1:0]  blcor;
   } sample_t;

   typedef struct packed {
      logic              valid;
      logic [TIME_W-1:0] ev_time;
   } event_t;

   typedef struct packed {
      logic               valid;
      logic [BLCOR_W-1:0] value;
   } energy_t;

   typedef struct packed {
      data_mode_e data_mode;
      logic [1:0] channel;
      logic [3:0] pipeline_len;   // extra delay on top of HIST_BASE_DELAY
   } readout_cfg_t;

   typedef struct packed {
      logic [TIME_WHOLE_W-1:0] whole;
      logic [TIME_FRAC_W-1:0]  frac;
   } time_split_t;

   // words after the mask, energy word included
   function automatic logic [NWORDS_W-1:0] mode_nwords(input data_mode_e mode);
      logic [NWORDS_W-1:0] n;
      case (mode)
         MODE_ENERGY:      n = NWORDS_W'(1);
         MODE_RAW:         n = NWORDS_W'(33);
         MODE_BLCOR_LONG:  n = NWORDS_W'(33);
         MODE_BLCOR_SHORT: n = NWORDS_W'(17);
         default:          n = NWORDS_W'(1);
      endcase
      return n;
   endfunction

endpackage

`default_nettype wire

//--- sample_history.sv
// delay line of recent samples for the readout record
// hist_word lags the selected input by HIST_BASE_DELAY + pipeline_len cycles
// mode change takes effect at the chain input, older entries keep the old source
`default_nettype none

module sample_history (
   input  wire                           clk,
   input  wire                           rst,
   input  wire dyn_pkg::sample_t         sample,
   input  wire dyn_pkg::readout_cfg_t    cfg,
   output logic [dyn_pkg::WORD_W-1:0]    hist_word
);
   import dyn_pkg::*;

   logic [BLCOR_W-1:0]    src_word;               // sample entering the chain
   logic [BLCOR_W-1:0]    chain [HIST_DEPTH];     // chain[k] lags input by k+1
   logic [HIST_TAP_W-1:0] tap_sel;

   // raw only in MODE_RAW, every other mode reads corrected samples
   always_comb begin
      if (cfg.data_mode == MODE_RAW) begin
         src_word = {{(BLCOR_W - SAMPLE_W){1'b0}}, sample.raw};  // zero extend
      end else begin
         src_word = sample.blcor;
      end
   end

   // output register adds one cycle, chain entry adds k+1
   // so tap index is L - 2
   assign tap_sel = HIST_TAP_W'(HIST_BASE_DELAY - 2) + HIST_TAP_W'(cfg.pipeline_len);

   always_ff @(posedge clk) begin
      if (rst) begin
         // empty chain reads as zeros
         for (int k = 0; k < HIST_DEPTH; k++) begin
            chain[k] <= '0;
         end
         hist_word <= '0;
      end else begin
         chain[0] <= src_word;
         for (int k = 1; k < HIST_DEPTH; k++) begin
            chain[k] <= chain[k-1];   // plain shift
         end
         hist_word <= {{(WORD_W - BLCOR_W){1'b0}}, chain[tap_sel]};
      end
   end

endmodule

`default_nettype wire

//--- trigger_time_encode.sv
// coincidence code for the MCU and whole/fraction split of the event time
// code is idle whenever no event strobe is present
`default_nettype none

module trigger_time_encode (
   input  wire                              clk,
   input  wire                              rst,
   input  wire dyn_pkg::event_t             event_in,
   output logic [dyn_pkg::MCU_CODE_W-1:0]   mcu_trigger,
   output dyn_pkg::time_split_t             trigger_time
);
   import dyn_pkg::*;

   logic sat;   // fraction too close to the next whole tick

   assign sat = &event_in.ev_time[11:6];

   always_ff @(posedge clk) begin
      if (rst) begin
         mcu_trigger  <= MCU_IDLE_CODE;
         trigger_time <= '0;
      end else begin
         if (!event_in.valid) begin
            mcu_trigger <= MCU_IDLE_CODE;            // back to idle next cycle
         end else if (sat) begin
            mcu_trigger <= MCU_SAT_CODE;
         end else begin
            mcu_trigger <= event_in.ev_time[11:4];   // top of the fraction
         end

         if (event_in.valid) begin                   // held until next event
            trigger_time.whole <= event_in.ev_time[19:12];
            trigger_time.frac  <= event_in.ev_time[11:0];
         end
      end
   end

endmodule

`default_nettype wire

//--- record_framer.sv
// builds one readout record per energy strobe or manual trigger
// preamble, word count, channel mask, samples, energy, one word per cycle
// strobes are ignored until the current record is finished, no back-pressure
`default_nettype none

module record_framer (
   input  wire                           clk,
   input  wire                           rst,
   input  wire dyn_pkg::energy_t         energy_in,
   input  wire                           trigger,
   input  wire dyn_pkg::readout_cfg_t    cfg,
   input  wire [dyn_pkg::WORD_W-1:0]     hist_word,
   output logic                          fifo_wr,
   output logic [dyn_pkg::WORD_W-1:0]    fifo_wdata
);
   import dyn_pkg::*;

   framer_state_e            state;
   logic                     start;        // record starts this cycle
   logic [NWORDS_W-1:0]      nwords_q;     // word count of current record
   logic [NUM_CHANNELS-1:0]  mask_q;       // one-hot channel
   logic [NWORDS_W-1:0]      data_cnt;     // words left, 0 is the energy slot
   logic [BLCOR_W-1:0]       energy_q;     // most recent energy

   assign start = (state == ST_IDLE) && (energy_in.valid || trigger);

   // count and mask fixed at start since cfg is only held per record
   always_ff @(posedge clk) begin
      if (start) begin
         nwords_q <= mode_nwords(cfg.data_mode);
         mask_q   <= NUM_CHANNELS'(1) << cfg.channel;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         state    <= ST_IDLE;
         data_cnt <= '0;
         energy_q <= '0;              // manual trigger before any energy reads 0
      end else begin
         case (state)
            ST_IDLE: begin
               if (start) begin
                  state    <= ST_PREAMBLE;
                  data_cnt <= mode_nwords(cfg.data_mode) - 1'b1;   // samples only
                  if (energy_in.valid) begin
                     energy_q <= energy_in.value;   // trigger alone keeps old value
                  end
               end
            end
            ST_PREAMBLE: begin
               state <= ST_NWORDS;
            end
            ST_NWORDS: begin
               state <= ST_MASK;
            end
            ST_MASK: begin
               state <= ST_DATA;
            end
            ST_DATA: begin
               if (data_cnt == '0) begin
                  state <= ST_IDLE;              // energy word goes out now
               end else begin
                  data_cnt <= data_cnt - 1'b1;
               end
            end
            default: begin
               state <= ST_IDLE;
            end
         endcase
      end
   end

   // write one word in every non-idle state
   // data words take hist_word live, so word i is the value seen at t+4+i
   always_comb begin
      fifo_wr = (state != ST_IDLE);
      case (state)
         ST_PREAMBLE: fifo_wdata = RECORD_PREAMBLE;
         ST_NWORDS:   fifo_wdata = {{(WORD_W - NWORDS_W){1'b0}}, nwords_q};
         ST_MASK:     fifo_wdata = {{(WORD_W - NUM_CHANNELS){1'b0}}, mask_q};
         ST_DATA: begin
            if (data_cnt == '0) begin
               fifo_wdata = {{(WORD_W - BLCOR_W){1'b0}}, energy_q};   // last slot
            end else begin
               fifo_wdata = hist_word;
            end
         end
         default:     fifo_wdata = '0;
      endcase
   end

endmodule

`default_nettype wire

//--- record_fifo.sv
// first-word-fall-through FIFO, head word shows on rdata while not_empty
// writes while full are lost, reads while empty are ignored
// pointers wrap freely so FIFO_DEPTH has to be a power of two
`default_nettype none

module record_fifo (
   input  wire                          clk,
   input  wire                          rst,
   input  wire                          wr,
   input  wire [dyn_pkg::WORD_W-1:0]    wdata,
   input  wire                          rd,
   output logic [dyn_pkg::WORD_W-1:0]   rdata,
   output logic                         not_empty,
   output logic                         nearly_full
);
   import dyn_pkg::*;

   logic [WORD_W-1:0]  mem [FIFO_DEPTH];
   logic [FIFO_AW-1:0] wr_ptr;
   logic [FIFO_AW-1:0] rd_ptr;
   logic [FIFO_CW-1:0] count;     // fill level 0..FIFO_DEPTH
   logic               push;
   logic               pop;

   assign push = wr && (count != FIFO_CW'(FIFO_DEPTH));   // drop when full
   assign pop  = rd && (count != '0);

   // storage
   always_ff @(posedge clk) begin
      if (push) begin
         mem[wr_ptr] <= wdata;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         if (push) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;       // both or neither
         endcase
      end
   end

   assign rdata       = mem[rd_ptr];   // head word, valid one cycle after first write
   assign not_empty   = (count != '0);
   assign nearly_full = (count >= FIFO_CW'(FIFO_NEARLY_FULL));

endmodule

`default_nettype wire

//--- dyn_trigger_readout.sv
// readout back end of one dynode trigger channel
// event, energy and trigger inputs are single-cycle strobes
// cfg must be held stable while a record is being written
`default_nettype none

module dyn_trigger_readout (
   input  wire                                clk,
   input  wire                                rst,
   input  wire dyn_pkg::sample_t              sample,
   input  wire dyn_pkg::event_t               event_in,
   input  wire dyn_pkg::energy_t              energy_in,
   input  wire                                trigger,
   input  wire dyn_pkg::readout_cfg_t         cfg,
   input  wire                                fifo_ren,
   output wire [dyn_pkg::WORD_W-1:0]          fifo_q,
   output wire                                fifo_ne,
   output wire                                fifo_nearly_full,
   output wire [dyn_pkg::MCU_CODE_W-1:0]      mcu_trigger,
   output wire dyn_pkg::time_split_t          trigger_time
);
   import dyn_pkg::*;

   wire [WORD_W-1:0] hist_word;    // delayed sample for the framer
   wire              fifo_wr;
   wire [WORD_W-1:0] fifo_wdata;

   sample_history u_history (
      .clk       (clk),
      .rst       (rst),
      .sample    (sample),
      .cfg       (cfg),
      .hist_word (hist_word)
   );

   trigger_time_encode u_time_enc (
      .clk          (clk),
      .rst          (rst),
      .event_in     (event_in),
      .mcu_trigger  (mcu_trigger),
      .trigger_time (trigger_time)
   );

   record_framer u_framer (
      .clk        (clk),
      .rst        (rst),
      .energy_in  (energy_in),
      .trigger    (trigger),
      .cfg        (cfg),
      .hist_word  (hist_word),
      .fifo_wr    (fifo_wr),
      .fifo_wdata (fifo_wdata)
   );

   // read side goes straight out to the board readout
   record_fifo u_fifo (
      .clk         (clk),
      .rst         (rst),
      .wr          (fifo_wr),
      .wdata       (fifo_wdata),
      .rd          (fifo_ren),
      .rdata       (fifo_q),
      .not_empty   (fifo_ne),
      .nearly_full (fifo_nearly_full)
   );

endmodule

`default_nettype wire

//--- tb_dyn_trigger_readout.sv
// directed testbench for the dynode trigger readout
// stimulus goes in 1 time unit after each rising edge, outputs read there too
// sel_log keeps the sample the history block selected in every cycle
`default_nettype none

module tb_dyn_trigger_readout;
   import dyn_pkg::*;

   localparam int CYCLE_LIMIT = 4000;   // tests need about 600 cycles

   logic              clk;
   logic              rst;
   sample_t           sample;
   event_t            event_in;
   energy_t           energy_in;
   logic              trigger;
   readout_cfg_t      cfg;
   logic              fifo_ren;
   logic [WORD_W-1:0] fifo_q;
   logic              fifo_ne;
   logic              fifo_nearly_full;
   logic [7:0]        mcu_trigger;
   time_split_t       trigger_time;

   integer            seed;
   int                cyc;              // rising edges so far
   int                ramp;
   bit                use_random;       // random samples instead of the ramp
   int                mismatches;
   int                other_errors;
   logic [15:0]       sel_log [0:4095]; // selected sample, zero extended, per cycle

   dyn_trigger_readout u_dyn_trigger_readout (
      .clk              (clk),
      .rst              (rst),
      .sample           (sample),
      .event_in         (event_in),
      .energy_in        (energy_in),
      .trigger          (trigger),
      .cfg              (cfg),
      .fifo_ren         (fifo_ren),
      .fifo_q           (fifo_q),
      .fifo_ne          (fifo_ne),
      .fifo_nearly_full (fifo_nearly_full),
      .mcu_trigger      (mcu_trigger),
      .trigger_time     (trigger_time)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // cycle counter, also the run limit
   always @(posedge clk) begin
      cyc <= cyc + 1;
      if (cyc >= CYCLE_LIMIT) begin
         $display("timeout: run reached %0d cycles before the tests finished", cyc);
         $display("errors: %0d mismatches, %0d other", mismatches, other_errors + 1);
         $display("Regression failed");
         $finish;
      end
   end

   // log what the DUT sees this cycle, then move to the next drive slot
   task automatic tick();
      logic [31:0] rnd;
      if (cfg.data_mode == MODE_RAW) sel_log[cyc] = {8'h00, sample.raw};
      else sel_log[cyc] = {4'h0, sample.blcor};
      @(posedge clk);
      #1;
      energy_in.valid = 1'b0;   // strobes last one cycle
      event_in.valid  = 1'b0;
      trigger         = 1'b0;
      fifo_ren        = 1'b0;
      if (use_random) begin
         rnd          = $random(seed);
         sample.raw   = rnd[7:0];
         sample.blcor = rnd[19:8];
      end else begin
         ramp         = ramp + 1;
         sample.raw   = ramp[7:0];
         sample.blcor = 12'(ramp * 7 + 161);   // distinct from raw
      end
   endtask

   task automatic settle(input int n);
      repeat (n) tick();
   endtask

   // record length after the mask, energy included
   function automatic int mode_word_count(input data_mode_e mode);
      case (mode)
         MODE_ENERGY:      return 1;
         MODE_BLCOR_SHORT: return 17;
         default:          return 33;   // raw and long corrected
      endcase
   endfunction

   // word k of a record that started at cycle t
   function automatic logic [15:0] predicted_word(input int t, input data_mode_e mode,
                                                  input logic [1:0] ch, input logic [11:0] en,
                                                  input int plen, input int k);
      int          n;
      logic [15:0] w;
      n = mode_word_count(mode);
      if (k == 0) w = 16'hA5A5;
      else if (k == 1) w = 16'(n);
      else if (k == 2) w = 16'(16'd1 << ch);   // one-hot channel
      else if (k == n + 2) w = {4'h0, en};      // energy last
      else w = sel_log[t + 1 + k - (HIST_BASE_DELAY + plen)];   // captured t+4+i
      return w;
   endfunction

   task automatic strobe_energy(input logic [11:0] value, output int t);
      energy_in.valid = 1'b1;
      energy_in.value = value;
      t = cyc;
      tick();
   endtask

   task automatic strobe_manual(output int t);
      trigger = 1'b1;
      t = cyc;
      tick();
   endtask

   // pops one whole record as words show up, word by word against the model
   task automatic drain_record(input int t, input data_mode_e mode, input logic [1:0] ch,
                               input logic [11:0] en, input int plen, input bit last);
      int          n;
      int          k;
      logic [15:0] exp_w;
      n = mode_word_count(mode) + 3;
      k = 0;
      while (k < n) begin
         if (fifo_ne) begin
            exp_w = predicted_word(t, mode, ch, en, plen, k);
            if (fifo_q !== exp_w) begin
               mismatches++;
               $display("MISMATCH time=%0t signal=fifo_q word=%0d expected=%h actual=%h",
                        $time, k, exp_w, fifo_q);
            end
            fifo_ren = 1'b1;
            k++;
         end
         tick();
      end
      if (last && fifo_ne !== 1'b0) begin   // fifo_ne drops after the last word
         mismatches++;
         $display("MISMATCH time=%0t signal=fifo_ne expected=0 actual=%b", $time, fifo_ne);
      end
   endtask

   task automatic reset_and_trigger_code();
      logic [23:0] times [5];
      logic [31:0] rnd;
      logic [7:0]  exp_code;
      time_split_t exp_time;
      if (fifo_ne !== 1'b0 || fifo_nearly_full !== 1'b0) begin
         mismatches++;
         $display("MISMATCH time=%0t signal=fifo_ne/fifo_nearly_full expected=00 actual=%b%b",
                  $time, fifo_ne, fifo_nearly_full);
      end
      if (mcu_trigger !== MCU_IDLE_CODE || trigger_time !== '0) begin
         mismatches++;
         $display("MISMATCH time=%0t signal=mcu_trigger/trigger_time expected=%h/0 actual=%h/%h",
                  $time, MCU_IDLE_CODE, mcu_trigger, trigger_time);
      end
      rnd      = $random(seed);
      times[0] = 24'h123456;   // plain fraction
      times[1] = 24'h0ABFC0;   // bits 11..6 all ones
      times[2] = 24'h3007FF;   // just below saturation
      times[3] = 24'hFFFFFF;
      times[4] = rnd[23:0];
      for (int i = 0; i < 5; i++) begin
         if (&times[i][11:6]) exp_code = MCU_SAT_CODE;
         else exp_code = times[i][11:4];
         exp_time.whole   = times[i][19:12];
         exp_time.frac    = times[i][11:0];
         event_in.valid   = 1'b1;
         event_in.ev_time = times[i];
         tick();
         if (mcu_trigger !== exp_code) begin
            mismatches++;
            $display("MISMATCH time=%0t signal=mcu_trigger expected=%h actual=%h",
                     $time, exp_code, mcu_trigger);
         end
         if (trigger_time !== exp_time) begin
            mismatches++;
            $display("MISMATCH time=%0t signal=trigger_time expected=%h actual=%h",
                     $time, exp_time, trigger_time);
         end
         event_in.ev_time = ~times[i];            // new time without a strobe
         tick();                                  // back to idle, time held
         if (mcu_trigger !== MCU_IDLE_CODE) begin
            mismatches++;
            $display("MISMATCH time=%0t signal=mcu_trigger expected=%h actual=%h",
                     $time, MCU_IDLE_CODE, mcu_trigger);
         end
         if (trigger_time !== exp_time) begin
            mismatches++;
            $display("MISMATCH time=%0t signal=trigger_time expected=%h actual=%h",
                     $time, exp_time, trigger_time);
         end
      end
   endtask

   task automatic energy_only_records();
      int          t;
      logic [11:0] en;
      for (int ch = 0; ch < 4; ch++) begin
         cfg = '{MODE_ENERGY, 2'(ch), 4'd0};
         settle(2);
         en = 12'(256 + 273 * ch);
         strobe_energy(en, t);
         drain_record(t, MODE_ENERGY, 2'(ch), en, 0, 1'b1);
      end
   endtask

   task automatic raw_sample_window(input int plen, input bit rand_samples);
      int t;
      use_random = rand_samples;
      cfg = '{MODE_RAW, 2'd1, 4'(plen)};
      settle(20);                              // fill the chain in raw mode
      strobe_energy(12'(12'h3C5 + plen), t);
      drain_record(t, MODE_RAW, 2'd1, 12'(12'h3C5 + plen), plen, 1'b1);
   endtask

   task automatic short_window_and_manual();
      int t;
      use_random = 1'b1;
      cfg = '{MODE_BLCOR_SHORT, 2'd2, 4'd4};
      settle(20);
      strobe_energy(12'hABC, t);
      drain_record(t, MODE_BLCOR_SHORT, 2'd2, 12'hABC, 4, 1'b1);
      settle(2);
      energy_in.value = 12'h35A;               // not strobed, latch keeps ABC
      strobe_manual(t);                        // reuses the latched energy
      drain_record(t, MODE_BLCOR_SHORT, 2'd2, 12'hABC, 4, 1'b1);
   endtask

   task automatic overlap_and_fill();
      int t;
      int t1;
      int t2;
      use_random = 1'b0;
      cfg = '{MODE_BLCOR_LONG, 2'd3, 4'd2};
      settle(20);
      strobe_energy(12'h5E1, t);
      settle(5);                               // framer now in ST_DATA
      energy_in.valid = 1'b1;
      energy_in.value = 12'h0F0;               // ignored, no relatch
      tick();
      settle(3);
      trigger = 1'b1;
      tick();
      drain_record(t, MODE_BLCOR_LONG, 2'd3, 12'h5E1, 2, 1'b1);
      settle(6);
      if (fifo_ne !== 1'b0) begin
         other_errors++;
         $display("ERROR time=%0t: a strobe during a record added words to the FIFO", $time);
      end
      // two records left unread, 36 + 20 words
      cfg = '{MODE_RAW, 2'd0, 4'd5};
      settle(20);
      strobe_energy(12'h222, t1);
      settle(40);
      if (fifo_nearly_full !== 1'b0) begin
         mismatches++;
         $display("MISMATCH time=%0t signal=fifo_nearly_full expected=0 actual=%b",
                  $time, fifo_nearly_full);
      end
      cfg = '{MODE_BLCOR_SHORT, 2'd2, 4'd7};
      settle(20);
      strobe_energy(12'h777, t2);
      settle(24);
      if (fifo_nearly_full !== 1'b1) begin
         mismatches++;
         $display("MISMATCH time=%0t signal=fifo_nearly_full expected=1 actual=%b",
                  $time, fifo_nearly_full);
      end
      drain_record(t1, MODE_RAW, 2'd0, 12'h222, 5, 1'b0);
      if (fifo_nearly_full !== 1'b0 || fifo_ne !== 1'b1) begin
         mismatches++;
         $display("MISMATCH time=%0t signal=fifo_nearly_full/fifo_ne expected=01 actual=%b%b",
                  $time, fifo_nearly_full, fifo_ne);
      end
      drain_record(t2, MODE_BLCOR_SHORT, 2'd2, 12'h777, 7, 1'b1);
   endtask

   initial begin
      seed         = 58311;
      cyc          = 0;
      ramp         = 0;
      use_random   = 1'b0;
      mismatches   = 0;
      other_errors = 0;
      rst          = 1'b1;
      sample       = '0;
      event_in     = '0;
      energy_in    = '0;
      trigger      = 1'b0;
      cfg          = '{MODE_ENERGY, 2'd0, 4'd0};
      fifo_ren     = 1'b0;
      repeat (5) tick();
      rst = 1'b0;
      reset_and_trigger_code();
      energy_only_records();
      raw_sample_window(0, 1'b0);
      raw_sample_window(9, 1'b1);
      short_window_and_manual();
      overlap_and_fill();
      $display("errors: %0d mismatches, %0d other", mismatches, other_errors);
      if (mismatches == 0 && other_errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

//--- dyn_trigger_readout.f
dyn_pkg.sv
sample_history.sv
trigger_time_encode.sv
record_framer.sv
record_fifo.sv
dyn_trigger_readout.sv
tb_dyn_trigger_readout.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and judge the result from the log.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal \
   --top-module tb_dyn_trigger_readout \
   -f dyn_trigger_readout.f \
   --Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
   echo "verilator build failed"
   exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -q "^Regression passed$" sim.log; then
   exit 0
fi
echo "pass line not found in sim.log"
exit 1
